//--- logic/game_pkg.sv
package game_pkg;

    // One button pattern or one stored sequence entry
    typedef logic [3:0] move_t;

    // Settings register, read back in bits 1:0
    typedef struct packed {
        logic short_game;
        logic fast_timeout;
    } game_settings_t;

    // FSM states
    typedef enum logic [3:0] {
        st_idle       = 4'd0,
        st_prep       = 4'd1,
        st_show_on    = 4'd2,
        st_show_off   = 4'd3,
        st_wait_press = 4'd4,
        st_check      = 4'd5,
        st_next_entry = 4'd6,
        st_next_round = 4'd7,
        st_won        = 4'd8,
        st_lost       = 4'd9
    } game_state_e;

    // Wishbone map with sequence entries at 0 to 15
    localparam logic [4:0] SETTINGS_ADR = 5'd16;

    // Rounds played when short_game is set
    localparam int SHORT_ROUNDS = 4;

endpackage

//--- logic/game_ctrl_if.sv
`timescale 1ns/1ps

interface game_ctrl_if ();
    // Strobes from the FSM
    logic clr_addr;
    logic inc_addr;
    logic clr_round;
    logic inc_round;
    logic clr_timer;
    logic run_timer;
    logic show_leds;
    logic latch_press;

    // Status flags from the datapath
    logic addr_eq_round;
    logic last_round;
    logic timer_done;
    logic show_done;
    logic press_seen;
    logic press_ok;

    modport ctrl (
        output clr_addr, inc_addr, clr_round, inc_round,
        output clr_timer, run_timer, show_leds, latch_press,
        input  addr_eq_round, last_round, timer_done, show_done, press_seen, press_ok
    );

    modport dp (
        input  clr_addr, inc_addr, clr_round, inc_round,
        input  clr_timer, run_timer, show_leds, latch_press,
        output addr_eq_round, last_round, timer_done, show_done, press_seen, press_ok
    );
endinterface

//--- logic/game_cfg_wb.sv
`timescale 1ns/1ps

module game_cfg_wb
    import game_pkg::*;
#(
    parameter int SEQ_DEPTH = 16
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [4:0]                   wb_adr,
    input  logic [7:0]                   wb_dat_w,
    output logic [7:0]                   wb_dat_r,
    output logic                         wb_ack,
    input  logic                         busy,
    input  logic [$clog2(SEQ_DEPTH)-1:0] rd_addr,
    output move_t                        rd_data,
    output game_settings_t               settings
);
    localparam int ADDR_W = $clog2(SEQ_DEPTH);

    move_t seq_mem [SEQ_DEPTH];
    logic  wb_req;
    logic  adr_is_seq;
    logic  adr_is_cfg;
    logic  wr_en;

    // New request only while no ack is pending
    assign wb_req     = wb_cyc && wb_stb && !wb_ack;
    assign adr_is_seq = wb_adr < 5'(SEQ_DEPTH);
    assign adr_is_cfg = wb_adr == SETTINGS_ADR;

    // During a game writes are acked but go nowhere
    assign wr_en = wb_req && wb_we && !busy;

    always_ff @(posedge clock) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            settings <= '0;
        end else if (wr_en && adr_is_cfg) begin
            settings <= game_settings_t'(wb_dat_w[1:0]);
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en && adr_is_seq) begin
            seq_mem[wb_adr[ADDR_W-1:0]] <= wb_dat_w[3:0];
        end
    end

    // Read data lands together with the ack
    always_ff @(posedge clock) begin
        if (wb_req && !wb_we) begin
            if (adr_is_cfg) begin
                wb_dat_r <= {6'd0, settings};
            end else if (adr_is_seq) begin
                wb_dat_r <= {4'd0, seq_mem[wb_adr[ADDR_W-1:0]]};
            end else begin
                wb_dat_r <= 8'd0;
            end
        end
    end

    // Entry under the game's address counter
    assign rd_data = seq_mem[rd_addr];

endmodule

//--- logic/game_datapath.sv
`timescale 1ns/1ps

module game_datapath
    import game_pkg::*;
#(
    parameter int SEQ_DEPTH      = 16,
    parameter int TIMEOUT_CYCLES = 64,
    parameter int SHOW_CYCLES    = 8
) (
    input  logic                         clock,
    input  logic                         rst,
    input  move_t                        buttons,
    input  game_settings_t               settings,
    input  move_t                        rd_data,
    game_ctrl_if.dp                      ctl,
    output logic [$clog2(SEQ_DEPTH)-1:0] rd_addr,
    output move_t                        leds,
    output logic [3:0]                   round_num
);
    localparam int ADDR_W   = $clog2(SEQ_DEPTH);
    localparam int TMR_W    = $clog2(TIMEOUT_CYCLES + 2 * SHOW_CYCLES);
    localparam int TMO_HALF = TIMEOUT_CYCLES / 2;

    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] round_q;
    logic [ADDR_W-1:0] final_round;
    logic [TMR_W-1:0]  timer_q;
    move_t             buttons_q;
    move_t             press_q;
    logic              press_edge;
    logic              press_seen_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            addr_q <= '0;
        end else if (ctl.clr_addr) begin
            addr_q <= '0;
        end else if (ctl.inc_addr) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            round_q <= '0;
        end else if (ctl.clr_round) begin
            round_q <= '0;
        end else if (ctl.inc_round) begin
            round_q <= round_q + 1'b1;
        end
    end

    // Shared by the show phases and the press timeout
    always_ff @(posedge clock) begin
        if (rst) begin
            timer_q <= '0;
        end else if (ctl.clr_timer) begin
            timer_q <= '0;
        end else if (ctl.run_timer) begin
            timer_q <= timer_q + 1'b1;
        end
    end

    // Zero to nonzero on the buttons counts as one press
    assign press_edge = (buttons_q == '0) && (buttons != '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            buttons_q    <= '0;
            press_seen_q <= 1'b0;
        end else begin
            buttons_q    <= buttons;
            press_seen_q <= ctl.latch_press && press_edge;
        end
    end

    always_ff @(posedge clock) begin
        if (ctl.latch_press && press_edge) begin
            press_q <= buttons;
        end
    end

    assign final_round = settings.short_game ? ADDR_W'(SHORT_ROUNDS - 1)
                                             : ADDR_W'(SEQ_DEPTH - 1);

    assign ctl.addr_eq_round = addr_q == round_q;
    assign ctl.last_round    = round_q == final_round;
    assign ctl.press_seen    = press_seen_q;
    assign ctl.press_ok      = press_q == rd_data;

    // Counter keeps running from the lit half into the dark half.
    // The dark half ends one cycle early, the transit state after it is dark too
    assign ctl.show_done = (timer_q == TMR_W'(SHOW_CYCLES - 1))
                        || (timer_q == TMR_W'(2 * SHOW_CYCLES - 2));

    // FSM paces run_timer, so the half count covers both limits
    assign ctl.timer_done = timer_q == TMR_W'(TMO_HALF);

    // latch_press is high exactly during the player's turn
    always_comb begin
        if (ctl.show_leds) begin
            leds = rd_data;
        end else if (ctl.latch_press) begin
            leds = buttons;
        end else begin
            leds = '0;
        end
    end

    assign rd_addr   = addr_q;
    assign round_num = 4'(round_q);

endmodule

//--- logic/game_control.sv
`timescale 1ns/1ps

module game_control
    import game_pkg::*;
(
    input  logic           clock,
    input  logic           rst,
    input  logic           start,
    input  game_settings_t settings,
    game_ctrl_if.ctrl      ctl,
    output logic           ready,
    output logic           won,
    output logic           lost,
    output logic           player_turn,
    output logic           busy,
    output game_state_e    state
);
    game_state_e next_state;
    logic        after_show;
    logic        pace;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // prep and next_entry are shared by the show and the play path
    always_ff @(posedge clock) begin
        if (rst) begin
            after_show <= 1'b0;
            pace       <= 1'b0;
        end else begin
            after_show <= state == st_show_off;
            pace       <= (state == st_wait_press) && !pace;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle, st_won, st_lost: begin
                if (start) begin
                    next_state = st_prep;
                end
            end
            st_prep: begin
                next_state = after_show ? st_wait_press : st_show_on;
            end
            st_show_on: begin
                if (ctl.show_done) begin
                    next_state = st_show_off;
                end
            end
            st_show_off: begin
                if (ctl.show_done) begin
                    next_state = ctl.addr_eq_round ? st_prep : st_next_entry;
                end
            end
            st_wait_press: begin
                if (ctl.press_seen) begin
                    next_state = st_check;
                end else if (ctl.timer_done) begin
                    next_state = st_lost;
                end
            end
            st_check: begin
                if (!ctl.press_ok) begin
                    next_state = st_lost;
                end else if (!ctl.addr_eq_round) begin
                    next_state = st_next_entry;
                end else if (ctl.last_round) begin
                    next_state = st_won;
                end else begin
                    next_state = st_next_round;
                end
            end
            st_next_entry: begin
                next_state = after_show ? st_show_on : st_wait_press;
            end
            st_next_round: begin
                next_state = st_show_on;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    assign won         = state == st_won;
    assign lost        = state == st_lost;
    assign ready       = (state == st_idle) || won || lost;
    assign busy        = !ready;
    assign player_turn = state == st_wait_press;

    assign ctl.clr_addr    = (state == st_prep) || (state == st_next_round);
    assign ctl.inc_addr    = state == st_next_entry;
    // Only a fresh game clears the round
    assign ctl.clr_round   = (state == st_prep) && !after_show;
    assign ctl.inc_round   = state == st_next_round;
    assign ctl.clr_timer   = (state == st_prep) || (state == st_next_entry)
                          || (state == st_next_round);
    assign ctl.show_leds   = state == st_show_on;
    assign ctl.latch_press = player_turn;

    // Normal limit steps every other cycle, fast limit every cycle
    assign ctl.run_timer = (state == st_show_on) || (state == st_show_off)
                        || (player_turn && (settings.fast_timeout || pace));

endmodule

//--- logic/hex7seg.sv
`timescale 1ns/1ps

module hex7seg (
    input  logic [3:0] value,
    output logic [6:0] segments
);
    // Bit order gfedcba, segment lit when low
    always_comb begin
        case (value)
            4'h0:    segments = 7'b1000000;
            4'h1:    segments = 7'b1111001;
            4'h2:    segments = 7'b0100100;
            4'h3:    segments = 7'b0110000;
            4'h4:    segments = 7'b0011001;
            4'h5:    segments = 7'b0010010;
            4'h6:    segments = 7'b0000010;
            4'h7:    segments = 7'b1111000;
            4'h8:    segments = 7'b0000000;
            4'h9:    segments = 7'b0010000;
            4'hA:    segments = 7'b0001000;
            4'hB:    segments = 7'b0000011;
            4'hC:    segments = 7'b1000110;
            4'hD:    segments = 7'b0100001;
            4'hE:    segments = 7'b0000110;
            default: segments = 7'b0001110;
        endcase
    end

endmodule

//--- logic/memory_game_top.sv
`timescale 1ns/1ps

module memory_game_top
    import game_pkg::*;
#(
    parameter int SEQ_DEPTH      = 16,
    parameter int TIMEOUT_CYCLES = 64,
    parameter int SHOW_CYCLES    = 8
) (
    input  logic       clock,
    input  logic       rst,
    input  logic       start,
    input  logic [3:0] buttons,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [4:0] wb_adr,
    input  logic [7:0] wb_dat_w,
    output logic [7:0] wb_dat_r,
    output logic       wb_ack,
    output logic       ready,
    output logic       won,
    output logic       lost,
    output logic       player_turn,
    output logic [3:0] leds,
    output logic [6:0] round_seg
);
    game_settings_t               settings;
    move_t                        rd_data;
    logic [$clog2(SEQ_DEPTH)-1:0] rd_addr;
    logic [3:0]                   round_num;
    logic                         busy;

    // Strobes and flags between FSM and datapath
    game_ctrl_if ctl_bus ();

    game_cfg_wb #(
        .SEQ_DEPTH ( SEQ_DEPTH )
    ) cfg (
        .clock    ( clock    ),
        .rst      ( rst      ),
        .wb_cyc   ( wb_cyc   ),
        .wb_stb   ( wb_stb   ),
        .wb_we    ( wb_we    ),
        .wb_adr   ( wb_adr   ),
        .wb_dat_w ( wb_dat_w ),
        .wb_dat_r ( wb_dat_r ),
        .wb_ack   ( wb_ack   ),
        .busy     ( busy     ),
        .rd_addr  ( rd_addr  ),
        .rd_data  ( rd_data  ),
        .settings ( settings )
    );

    game_datapath #(
        .SEQ_DEPTH      ( SEQ_DEPTH      ),
        .TIMEOUT_CYCLES ( TIMEOUT_CYCLES ),
        .SHOW_CYCLES    ( SHOW_CYCLES    )
    ) datapath (
        .clock     ( clock     ),
        .rst       ( rst       ),
        .buttons   ( buttons   ),
        .settings  ( settings  ),
        .rd_data   ( rd_data   ),
        .ctl       ( ctl_bus   ),
        .rd_addr   ( rd_addr   ),
        .leds      ( leds      ),
        .round_num ( round_num )
    );

    // FSM state is left open here for probing
    game_control control (
        .clock       ( clock       ),
        .rst         ( rst         ),
        .start       ( start       ),
        .settings    ( settings    ),
        .ctl         ( ctl_bus     ),
        .ready       ( ready       ),
        .won         ( won         ),
        .lost        ( lost        ),
        .player_turn ( player_turn ),
        .busy        ( busy        ),
        .state       (             )
    );

    // Round display
    hex7seg round_display (
        .value    ( round_num ),
        .segments ( round_seg )
    );

endmodule

//--- sim/memory_game_checker.sv
`timescale 1ns/1ps

module memory_game_checker (
    input logic       clock,
    input logic       rst,
    input logic       start,
    input logic       wb_cyc,
    input logic       wb_stb,
    input logic       wb_ack,
    input logic       ready,
    input logic       won,
    input logic       lost,
    input logic       player_turn,
    input logic [3:0] leds
);
    logic started;
    // Number of failed assertions so far
    int   fail_count = 0;

    // Set by the first start after reset
    always_ff @(posedge clock) begin
        if (rst) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    won_lost_exclusive: assert property (@(posedge clock) disable iff (rst)
        !(won && lost))
        else begin
            $error("won and lost are high together");
            fail_count++;
        end

    // Ack only answers a request seen in the cycle before
    ack_after_request: assert property (@(posedge clock) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            $error("wb_ack without a preceding cyc and stb");
            fail_count++;
        end

    ack_single_cycle: assert property (@(posedge clock) disable iff (rst)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack lasted two cycles");
            fail_count++;
        end

    ready_not_in_turn: assert property (@(posedge clock) disable iff (rst)
        !(ready && player_turn))
        else begin
            $error("ready and player_turn are high together");
            fail_count++;
        end

    leds_dark_before_start: assert property (@(posedge clock) disable iff (rst)
        !started |-> leds == 4'd0)
        else begin
            $error("leds lit before the first start");
            fail_count++;
        end

endmodule

bind memory_game_top memory_game_checker checks (
    .clock       ( clock       ),
    .rst         ( rst         ),
    .start       ( start       ),
    .wb_cyc      ( wb_cyc      ),
    .wb_stb      ( wb_stb      ),
    .wb_ack      ( wb_ack      ),
    .ready       ( ready       ),
    .won         ( won         ),
    .lost        ( lost        ),
    .player_turn ( player_turn ),
    .leds        ( leds        )
);

//--- sim/memory_game_tb.sv
`timescale 1ns/1ps

module memory_game_tb
    import game_pkg::*;
();
    localparam int SEQ_DEPTH       = 16;
    localparam int TIMEOUT_CYCLES  = 64;
    localparam int SHOW_CYCLES     = 8;
    localparam int NUM_GAMES       = 6;
    localparam int WATCHDOG_CYCLES = SEQ_DEPTH * SEQ_DEPTH
                                   * (2 * SHOW_CYCLES + TIMEOUT_CYCLES) * NUM_GAMES;

    // Lit segments gfedcba per hex digit, the display drives them low
    localparam logic [6:0] SEG_ON [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    typedef struct packed {
        logic       is_won;
        logic [4:0] rounds;
    } result_t;

    logic       clock;
    logic       rst;
    logic       start;
    logic [3:0] buttons;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [4:0] wb_adr;
    logic [7:0] wb_dat_w;
    logic [7:0] wb_dat_r;
    logic       wb_ack;
    logic       ready;
    logic       won;
    logic       lost;
    logic       player_turn;
    logic [3:0] leds;
    logic [6:0] round_seg;

    move_t   seq_model [SEQ_DEPTH];
    move_t   press_val [$];
    int      press_dly [$];
    move_t   shown_q [$];
    move_t   shown_now;
    move_t   shown_prev;
    result_t expected;
    event    game_done;

    memory_game_top UUT (
        .clock       ( clock       ),
        .rst         ( rst         ),
        .start       ( start       ),
        .buttons     ( buttons     ),
        .wb_cyc      ( wb_cyc      ),
        .wb_stb      ( wb_stb      ),
        .wb_we       ( wb_we       ),
        .wb_adr      ( wb_adr      ),
        .wb_dat_w    ( wb_dat_w    ),
        .wb_dat_r    ( wb_dat_r    ),
        .wb_ack      ( wb_ack      ),
        .ready       ( ready       ),
        .won         ( won         ),
        .lost        ( lost        ),
        .player_turn ( player_turn ),
        .leds        ( leds        ),
        .round_seg   ( round_seg   )
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        abort_run($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    // Bound protocol assertions
    always @(negedge clock) begin
        assert (UUT.checks.fail_count == 0)
            else abort_run("A bound protocol assertion failed");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped");
    endtask

    // Outcome of a game from the press list alone
    function automatic result_t expected_result(input move_t seq [SEQ_DEPTH],
            input game_settings_t cfg, input move_t presses [$], input int delays [$]);
        result_t res;
        int      limit;
        int      rounds;
        int      k;
        int      r;
        int      i;
        limit  = cfg.fast_timeout ? TIMEOUT_CYCLES / 2 : TIMEOUT_CYCLES;
        rounds = cfg.short_game ? SHORT_ROUNDS : SEQ_DEPTH;
        k      = 0;
        for (r = 0; r < rounds; r++) begin
            for (i = 0; i <= r; i++) begin
                if (k >= presses.size() || delays[k] >= limit || presses[k] != seq[i]) begin
                    res.is_won = 1'b0;
                    res.rounds = 5'(r);
                    return res;
                end
                k++;
            end
        end
        res.is_won = 1'b1;
        res.rounds = 5'(rounds);
        return res;
    endfunction

    task automatic wb_cycle(input logic we, input logic [4:0] adr, input logic [7:0] dat,
                            output logic [7:0] rdat);
        int waited;
        waited = 0;
        @(negedge clock);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do begin
            @(negedge clock);
            waited++;
            if (waited > 4) begin
                abort_run($sformatf("No Wishbone ack for address %0d", adr));
            end
        end while (!wb_ack);
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [4:0] adr, output logic [7:0] dat);
        wb_cycle(1'b0, adr, 8'd0, dat);
    endtask

    task automatic load_sequence();
        int a;
        for (a = 0; a < SEQ_DEPTH; a++) begin
            seq_model[a] = move_t'($urandom_range(15, 1));
            wb_write(5'(a), {4'd0, seq_model[a]});
        end
    endtask

    task automatic check_readback(input game_settings_t cfg);
        logic [7:0] got;
        int         a;
        for (a = 0; a < SEQ_DEPTH; a++) begin
            wb_read(5'(a), got);
            assert (got == {4'd0, seq_model[a]})
                else abort_run($sformatf("[ERROR] %0t ns: entry %0d reads %h, expected %h",
                                         $time, a, got, seq_model[a]));
        end
        wb_read(SETTINGS_ADR, got);
        assert (got == {6'd0, cfg})
            else abort_run($sformatf("[ERROR] %0t ns: settings read %h, expected %h",
                                     $time, got, cfg));
    endtask

    task automatic clear_presses();
        press_val.delete();
        press_dly.delete();
    endtask

    // Correct presses for one round with short random delays
    task automatic add_round(input int r);
        int i;
        for (i = 0; i <= r; i++) begin
            press_val.push_back(seq_model[i]);
            press_dly.push_back($urandom_range(3, 0));
        end
    endtask

    task automatic press_button(input move_t value, input int delay);
        repeat (delay) @(negedge clock);
        buttons = value;
        @(negedge clock);
        // LEDs follow the buttons while the turn lasts
        assert (!player_turn || leds == value)
            else abort_run($sformatf("[ERROR] %0t ns: leds %h during the turn, expected %h",
                                     $time, leds, value));
        @(negedge clock);
        buttons = '0;
        while (player_turn) begin
            @(negedge clock);
        end
    endtask

    task automatic play_game(input game_settings_t cfg);
        int k;
        expected = expected_result(seq_model, cfg, press_val, press_dly);
        wb_write(SETTINGS_ADR, {6'd0, cfg});
        shown_q.delete();
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        for (k = 0; k < press_val.size(); k++) begin
            while (!(player_turn || won || lost)) begin
                @(negedge clock);
            end
            if (won || lost) begin
                break;
            end
            press_button(press_val[k], press_dly[k]);
        end
        while (!(won || lost)) begin
            @(negedge clock);
        end
        -> game_done;
        @(negedge clock);
    endtask

    // Records each pattern that lights up outside the player's turn
    always @(negedge clock) begin
        shown_now = player_turn ? '0 : leds;
        if (shown_now != '0 && shown_prev == '0) begin
            shown_q.push_back(shown_now);
        end
        shown_prev = shown_now;
    end

    initial begin
        logic [3:0] round_exp;
        int         n_shown;
        int         idx;
        int         r;
        int         i;
        forever begin
            @(game_done);
            assert (won == expected.is_won && lost == !expected.is_won)
                else abort_run($sformatf("[ERROR] %0t ns: won=%b lost=%b, expected won=%b",
                                         $time, won, lost, expected.is_won));
            round_exp = expected.is_won ? 4'(expected.rounds - 5'd1) : 4'(expected.rounds);
            assert (round_seg == ~SEG_ON[round_exp])
                else abort_run($sformatf("[ERROR] %0t ns: round_seg %b, expected round %0d",
                                         $time, round_seg, round_exp));
            assert (ready)
                else abort_run($sformatf("[ERROR] %0t ns: ready low after game end", $time));
            // Round r shows entries 0 to r
            n_shown = expected.is_won ? int'(expected.rounds) : int'(expected.rounds) + 1;
            idx     = 0;
            for (r = 0; r < n_shown; r++) begin
                for (i = 0; i <= r; i++) begin
                    assert (idx < shown_q.size() && shown_q[idx] == seq_model[i])
                        else abort_run($sformatf("[ERROR] %0t ns: show %0d of round %0d wrong",
                                                 $time, i, r));
                    idx++;
                end
            end
            assert (shown_q.size() == idx)
                else abort_run($sformatf("[ERROR] %0t ns: %0d patterns shown, expected %0d",
                                         $time, shown_q.size(), idx));
        end
    end

    initial begin
        game_settings_t cfg;
        int             r;
        void'($urandom(32'h1d6a));
        rst        = 1'b1;
        start      = 1'b0;
        buttons    = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        shown_prev = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        // Bus readback of random entries and settings
        load_sequence();
        cfg = game_settings_t'($urandom_range(3, 0));
        wb_write(SETTINGS_ADR, {6'd0, cfg});
        check_readback(cfg);

        // Short game, all presses right
        clear_presses();
        for (r = 0; r < SHORT_ROUNDS; r++) begin
            add_round(r);
        end
        play_game(game_settings_t'(2'b10));

        // Wrong second entry in round 2
        load_sequence();
        clear_presses();
        add_round(0);
        add_round(1);
        press_val.push_back(seq_model[0]);
        press_dly.push_back(1);
        press_val.push_back(move_t'(seq_model[1] % 15 + 1));
        press_dly.push_back(1);
        play_game(game_settings_t'(2'b10));

        // Late press under the fast limit
        clear_presses();
        add_round(0);
        press_val.push_back(seq_model[0]);
        press_dly.push_back(40);
        play_game(game_settings_t'(2'b11));
        press_val.push_back(seq_model[1]);
        press_dly.push_back(2);
        add_round(2);
        add_round(3);
        play_game(game_settings_t'(2'b10));

        // Bus writes while the game runs
        load_sequence();
        clear_presses();
        for (r = 0; r < SHORT_ROUNDS; r++) begin
            add_round(r);
        end
        fork
            play_game(game_settings_t'(2'b10));
            begin
                @(posedge player_turn);
                wb_write(5'd3, {4'd0, ~seq_model[3]});
                wb_write(SETTINGS_ADR, 8'h01);
            end
        join
        check_readback(game_settings_t'(2'b10));

        // Full depth game
        load_sequence();
        clear_presses();
        for (r = 0; r < SEQ_DEPTH; r++) begin
            add_round(r);
        end
        play_game(game_settings_t'(2'b00));

        if (UUT.checks.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("A bound protocol assertion failed");
        end
    end

endmodule

//--- tb.f
logic/game_pkg.sv
logic/game_ctrl_if.sv
logic/game_cfg_wb.sv
logic/game_datapath.sv
logic/game_control.sv
logic/hex7seg.sv
logic/memory_game_top.sv
sim/memory_game_checker.sv
sim/memory_game_tb.sv

//--- Bender.yml
package:
  name: memory_game

sources:
  - logic/game_pkg.sv
  - logic/game_ctrl_if.sv
  - logic/game_cfg_wb.sv
  - logic/game_datapath.sv
  - logic/game_control.sv
  - logic/hex7seg.sv
  - logic/memory_game_top.sv
  - target: test
    files:
      - sim/memory_game_checker.sv
      - sim/memory_game_tb.sv
